// ==== common/cps_pkg.sv ====
// Shared types and constants for the game memory block
// SDRAM region map, slot indices and the packed request and command words

package cps_pkg;

    // Widths
    typedef logic [21:0] sdram_addr_t;
    typedef logic [22:0] ioctl_addr_t;
    typedef logic [15:0] word_t;
    typedef logic [31:0] sdram_data_t;
    typedef logic [1:0]  bank_t;
    typedef logic [1:0]  wrmask_t;
    typedef logic [1:0]  slot_idx_t;

    // Region offsets in SDRAM words, the download stream uses twice these
    localparam sdram_addr_t CPU_OFFSET = 22'h00_0000;
    localparam sdram_addr_t SND_OFFSET = 22'h08_0000;
    localparam sdram_addr_t GFX_OFFSET = 22'h0A_8000;
    localparam sdram_addr_t RAM_OFFSET = 22'h3A_8000;

    // Client slots
    localparam int NSLOTS = 4;

    localparam slot_idx_t SLOT_ROM = 2'd0;
    localparam slot_idx_t SLOT_RAM = 2'd1;
    localparam slot_idx_t SLOT_GFX = 2'd2;
    localparam slot_idx_t SLOT_SND = 2'd3;

    // One client request, held steady by the client until its ok pulse
    typedef struct packed {
        logic        cs;
        logic        wr;
        sdram_addr_t addr;
        wrmask_t     wrmask;
        word_t       din;
    } slot_req_t;

    // Command word to the SDRAM controller
    typedef struct packed {
        sdram_addr_t addr;
        bank_t       bank;
        logic        rnw;
        wrmask_t     wrmask;
        word_t       data_write;
    } sdram_cmd_t;

    // Download write towards the SDRAM controller
    typedef struct packed {
        sdram_addr_t addr;
        logic [7:0]  data;
        wrmask_t     mask;
        bank_t       bank;
        logic        we;
    } prog_wr_t;

    // Slot multiplexer sequencing
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_DATA,
        DONE
    } mux_state_t;

endpackage

// ==== source/frac_cen.sv ====
// Fractional clock enable
// Produces N single-cycle pulses in every M clock cycles, N below M
`timescale 1ns/1ns

module frac_cen #(
    parameter int N = 5,
    parameter int M = 24
) (
    input  logic VB,
    input  logic arst_n,
    output logic cen
);

    // Sum never exceeds M+N-1
    localparam int W = $clog2(N + M);

    localparam logic [W-1:0] STEP = W'(N);
    localparam logic [W-1:0] WRAP = W'(M);

    logic [W-1:0] acc;
    logic [W-1:0] sum;

    assign sum = acc + STEP;

    // Each wrap of the accumulator is one enable pulse
    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
            cen <= 1'b0;
        end else if (sum >= WRAP) begin
            acc <= sum - WRAP;
            cen <= 1'b1;
        end else begin
            acc <= sum;
            cen <= 1'b0;
        end
    end

endmodule

// ==== loader/rom_loader.sv ====
// ROM download mapper
// Turns the loader byte stream into SDRAM byte writes with bank and mask,
// and bytes past the graphics region into configuration strobes
`timescale 1ns/1ns

module rom_loader
    import cps_pkg::*;
(
    input  logic        VB,
    input  logic        arst_n,
    input  logic        downloading,
    input  ioctl_addr_t ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic        ioctl_wr,
    input  logic        sdram_ack,
    output prog_wr_t    prog,
    output logic        cfg_we
);

    // Region limits in the byte-addressed download stream
    localparam ioctl_addr_t SND_START = {SND_OFFSET, 1'b0};
    localparam ioctl_addr_t CFG_START = {RAM_OFFSET, 1'b0};

    logic        byte_wr;
    logic        in_cfg;
    logic        in_cpu;
    sdram_addr_t addr_q;
    logic [7:0]  data_q;
    wrmask_t     mask_q;
    bank_t       bank_q;
    logic        we_q;

    assign byte_wr = downloading && ioctl_wr;
    assign in_cfg  = ioctl_addr >= CFG_START;
    assign in_cpu  = ioctl_addr < SND_START;

    // Write strobe held until the controller takes it
    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            we_q   <= 1'b0;
            cfg_we <= 1'b0;
        end else begin
            cfg_we <= byte_wr && in_cfg;
            if (!downloading) begin
                we_q <= 1'b0;
            end else if (byte_wr && !in_cfg) begin
                we_q <= 1'b1;
            end else if (sdram_ack) begin
                we_q <= 1'b0;
            end
        end
    end

    // Byte payload, data also serves as the configuration byte
    always_ff @(posedge VB) begin
        if (byte_wr) begin
            data_q <= ioctl_data;
            addr_q <= ioctl_addr[22:1];
            // Even byte lands in the lower lane
            mask_q <= ioctl_addr[0] ? 2'b01 : 2'b10;
            // CPU code sits alone in bank 1
            bank_q <= in_cpu ? 2'd1 : 2'd0;
        end
    end

    assign prog = '{
        addr: addr_q,
        data: data_q,
        mask: mask_q,
        bank: bank_q,
        we:   we_q
    };

endmodule

// ==== sdram_mux/slot_arbiter.sv ====
// Round-robin arbiter for the SDRAM client slots
// Scans from the slot after the last one served
`timescale 1ns/1ns

module slot_arbiter
    import cps_pkg::*;
(
    input  logic              VB,
    input  logic              arst_n,
    input  logic [NSLOTS-1:0] cs_vec,
    input  logic              grant_take,
    output slot_idx_t         grant,
    output logic              grant_valid
);

    slot_idx_t last_q;

    // First requester after last_q, wrapping round to last_q itself
    always_comb begin
        slot_idx_t idx;
        grant       = last_q;
        grant_valid = 1'b0;
        for (int i = 1; i <= NSLOTS; i++) begin
            idx = last_q + slot_idx_t'(i);
            if (!grant_valid && cs_vec[idx]) begin
                grant       = idx;
                grant_valid = 1'b1;
            end
        end
    end

    // Starts at the top index so slot 0 wins first
    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            last_q <= slot_idx_t'(NSLOTS - 1);
        end else if (grant_take) begin
            last_q <= grant;
        end
    end

endmodule

// ==== sdram_mux/sdram_slot_mux.sv ====
// SDRAM slot multiplexer
// Shares one controller port among the ROM, RAM, GFX and sound slots,
// adds each slot's region offset and returns read data with an ok pulse
`timescale 1ns/1ns

module sdram_slot_mux
    import cps_pkg::*;
(
    input  logic                   VB,
    input  logic                   arst_n,
    input  logic                   downloading,
    input  slot_req_t [NSLOTS-1:0] slots,
    output logic [NSLOTS-1:0]      slot_ok,
    output sdram_data_t            slot_dout,
    output logic                   sdram_req,
    input  logic                   sdram_ack,
    input  logic                   data_rdy,
    input  sdram_data_t            data_read,
    output sdram_cmd_t             cmd,
    output logic                   refresh_en
);

    mux_state_t        state;
    slot_idx_t         grant;
    slot_idx_t         sel;
    logic              grant_valid;
    logic              grant_take;
    logic [NSLOTS-1:0] cs_vec;
    slot_req_t         granted;
    logic              slot_write;
    sdram_cmd_t        next_cmd;

    function automatic sdram_addr_t region_offset(input slot_idx_t s);
        case (s)
            SLOT_ROM: region_offset = CPU_OFFSET;
            SLOT_RAM: region_offset = RAM_OFFSET;
            SLOT_GFX: region_offset = GFX_OFFSET;
            default:  region_offset = SND_OFFSET;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < NSLOTS; i++) begin
            cs_vec[i] = slots[i].cs;
        end
    end

    slot_arbiter u_arbiter (
        .VB          ( VB          ),
        .arst_n      ( arst_n      ),
        .cs_vec      ( cs_vec      ),
        .grant_take  ( grant_take  ),
        .grant       ( grant       ),
        .grant_valid ( grant_valid )
    );

    // No slot gets the port while the loader owns it
    assign grant_take = (state == IDLE) && grant_valid && !downloading;

    assign granted    = slots[grant];
    // Work RAM is the only writable region
    assign slot_write = granted.wr && (grant == SLOT_RAM);

    always_comb begin
        next_cmd.addr       = region_offset(grant) + granted.addr;
        next_cmd.bank       = (grant == SLOT_ROM) ? 2'd1 : 2'd0;
        next_cmd.rnw        = !slot_write;
        next_cmd.wrmask     = slot_write ? granted.wrmask : 2'b11;
        next_cmd.data_write = granted.din;
    end

    // Refresh may run while nothing waits for the port
    assign refresh_en = (state == IDLE) && !grant_valid;

    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            sel       <= '0;
            sdram_req <= 1'b0;
            slot_ok   <= '0;
        end else begin
            slot_ok <= '0;
            case (state)
                IDLE: begin
                    if (grant_take) begin
                        sel       <= grant;
                        sdram_req <= 1'b1;
                        state     <= REQ;
                    end
                end
                REQ: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    // Writes also finish on data_rdy
                    if (data_rdy) begin
                        slot_ok[sel] <= 1'b1;
                        state        <= DONE;
                    end
                end
                // Gives the client one cycle to drop cs
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Command held for the whole request
    always_ff @(posedge VB) begin
        if (grant_take) begin
            cmd <= next_cmd;
        end
        if (state == WAIT_DATA && data_rdy) begin
            slot_dout <= data_read;
        end
    end

endmodule

// ==== source/game_mem_top.sv ====
// Game memory top level
// CPU clock enable, ROM download mapping and SDRAM slot sharing
`timescale 1ns/1ns

module game_mem_top
    import cps_pkg::*;
#(
    parameter int CEN_N = 5,
    parameter int CEN_M = 24
) (
    input  logic                   VB,
    input  logic                   arst_n,
    output logic                   cpu_cen,
    // ROM download
    input  logic                   downloading,
    input  ioctl_addr_t            ioctl_addr,
    input  logic [7:0]             ioctl_data,
    input  logic                   ioctl_wr,
    output prog_wr_t               prog,
    output logic                   cfg_we,
    // Client slots
    input  slot_req_t [NSLOTS-1:0] slots,
    output logic [NSLOTS-1:0]      slot_ok,
    output sdram_data_t            slot_dout,
    // SDRAM controller
    output logic                   sdram_req,
    input  logic                   sdram_ack,
    input  logic                   data_rdy,
    input  sdram_data_t            data_read,
    output sdram_cmd_t             cmd,
    output logic                   refresh_en
);

    // Main CPU enable, 5/24 of the clock by default
    frac_cen #(
        .N ( CEN_N ),
        .M ( CEN_M )
    ) u_cpu_cen (
        .VB     ( VB      ),
        .arst_n ( arst_n  ),
        .cen    ( cpu_cen )
    );

    rom_loader u_loader (
        .VB          ( VB          ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog        ( prog        ),
        .cfg_we      ( cfg_we      )
    );

    // Shares sdram_ack with the loader, only one side requests at a time
    sdram_slot_mux u_sdram_mux (
        .VB          ( VB          ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .slots       ( slots       ),
        .slot_ok     ( slot_ok     ),
        .slot_dout   ( slot_dout   ),
        .sdram_req   ( sdram_req   ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .cmd         ( cmd         ),
        .refresh_en  ( refresh_en  )
    );

endmodule

// ==== dv/tb_game_mem_asserts.sv ====
// Protocol checks on the SDRAM slot multiplexer
`timescale 1ns/1ns

module tb_game_mem_asserts
    import cps_pkg::*;
(
    input logic              VB,
    input logic              arst_n,
    input logic              downloading,
    input logic              sdram_req,
    input logic              sdram_ack,
    input sdram_cmd_t        cmd,
    input logic [NSLOTS-1:0] slot_ok
);

    // Request and command stay put until the controller acks
    req_held: assert property (
        @(posedge VB) disable iff (!arst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(cmd)
    ) else $error("sdram_req or cmd changed before sdram_ack");

    ok_onehot: assert property (
        @(posedge VB) disable iff (!arst_n)
        $onehot0(slot_ok)
    ) else $error("more than one slot_ok high");

    // Loader owns the port during a download
    no_ok_in_download: assert property (
        @(posedge VB) disable iff (!arst_n)
        downloading |-> slot_ok == '0
    ) else $error("slot_ok high while downloading");

endmodule

bind sdram_slot_mux tb_game_mem_asserts u_mux_asserts (
    .VB          ( VB          ),
    .arst_n      ( arst_n      ),
    .downloading ( downloading ),
    .sdram_req   ( sdram_req   ),
    .sdram_ack   ( sdram_ack   ),
    .cmd         ( cmd         ),
    .slot_ok     ( slot_ok     )
);

// ==== dv/tb_game_mem.sv ====
// Testbench for the game memory block
// Directed tests of download mapping, slot access, round robin and CPU enable
`timescale 1ns/1ns

module tb_game_mem
    import cps_pkg::*;
();

    localparam int CLK_NS = 8;
    localparam int CEN_N  = 5;
    localparam int CEN_M  = 24;
    // Room for twice the longest run of 12 handshakes, two enable windows and reset
    localparam int WATCHDOG_NS = 2 * (12 * 40 + 2 * 255 + 260) * CLK_NS;

    logic                   VB;
    logic                   arst_n;
    logic                   cpu_cen;
    logic                   downloading;
    ioctl_addr_t            ioctl_addr;
    logic [7:0]             ioctl_data;
    logic                   ioctl_wr;
    prog_wr_t               prog;
    logic                   cfg_we;
    slot_req_t [NSLOTS-1:0] slots;
    logic [NSLOTS-1:0]      slot_ok;
    sdram_data_t            slot_dout;
    logic                   sdram_req;
    logic                   sdram_ack;
    logic                   data_rdy;
    sdram_data_t            data_read;
    sdram_cmd_t             cmd;
    logic                   refresh_en;

    integer     seed;
    int         mismatches;
    int         failures;
    int         cfg_pulses;
    int         prog_writes;
    int         ok_count;
    logic       prog_we_q;
    prog_wr_t   last_prog;
    sdram_cmd_t seen_cmd;

    game_mem_top #(.CEN_N(CEN_N), .CEN_M(CEN_M)) UUT (.*);

    always #(CLK_NS / 2) VB = ~VB;

    // Memory contents as seen by the model, unique per word address
    function automatic sdram_data_t model_word(input sdram_addr_t a);
        model_word = {a, a[9:0] ^ 10'h2B5};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[ERROR] %s = %h, expected %h at %0t ns", name, got, exp, $time);
        mismatches++;
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        failures++;
    endtask

    // SDRAM controller model with 1 to 4 cycles of ack and data latency
    initial begin : sdram_model
        int          r;
        logic        slot_cycle;
        sdram_addr_t req_addr;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge VB);
            if (arst_n && (sdram_req || prog.we)) begin
                slot_cycle = sdram_req;
                req_addr   = cmd.addr;
                if (slot_cycle) seen_cmd = cmd;
                r = $random(seed);
                repeat (r & 3) @(posedge VB);
                sdram_ack <= 1'b1;
                @(posedge VB);
                sdram_ack <= 1'b0;
                if (slot_cycle) begin
                    r = $random(seed);
                    repeat (r & 3) @(posedge VB);
                    data_rdy  <= 1'b1;
                    data_read <= model_word(req_addr);
                    @(posedge VB);
                    data_rdy <= 1'b0;
                end
            end
        end
    end

    // Strobe counters
    always @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            cfg_pulses  <= 0;
            prog_writes <= 0;
            ok_count    <= 0;
            prog_we_q   <= 1'b0;
        end else begin
            if (cfg_we) cfg_pulses <= cfg_pulses + 1;
            if (slot_ok != '0) ok_count <= ok_count + 1;
            if (prog.we && !prog_we_q) begin
                prog_writes <= prog_writes + 1;
                last_prog   <= prog;
            end
            prog_we_q <= prog.we;
        end
    end

    // One loader byte, waits for the SDRAM write or the config strobe
    task automatic load_byte(input ioctl_addr_t a, input logic [7:0] d, input logic to_sdram);
        int n;
        int start_cfg;
        int start_wr;
        start_cfg = cfg_pulses;
        start_wr  = prog_writes;
        @(posedge VB);
        ioctl_addr <= a;
        ioctl_data <= d;
        ioctl_wr   <= 1'b1;
        @(posedge VB);
        ioctl_wr <= 1'b0;
        n = 0;
        while (n < 20 && (to_sdram ? (prog_writes == start_wr || prog.we)
                                   : cfg_pulses == start_cfg)) begin
            @(posedge VB);
            n++;
        end
        if (n == 20) report_failure("download byte was not taken");
    endtask

    task automatic slot_access(input slot_idx_t s, input logic wr, input sdram_addr_t a,
                               input wrmask_t m, input word_t d, output sdram_data_t dout);
        int n;
        @(posedge VB);
        slots[s] <= '{cs: 1'b1, wr: wr, addr: a, wrmask: m, din: d};
        n = 0;
        do begin
            @(posedge VB);
            n++;
        end while (!slot_ok[s] && n < 40);
        dout = slot_dout;
        slots[s].cs <= 1'b0;
        if (!slot_ok[s]) report_failure("slot access got no slot_ok");
    endtask

    task automatic round_robin();
        int        n;
        logic      found;
        slot_idx_t got;
        @(posedge VB);
        for (int i = 0; i < NSLOTS; i++) begin
            slots[i] <= '{cs: 1'b1, wr: 1'b0, addr: sdram_addr_t'(i * 16), wrmask: 2'b11, din: '0};
        end
        // Slot 0 goes first after reset
        for (int k = 0; k <= NSLOTS; k++) begin
            n = 0;
            do begin
                @(posedge VB);
                n++;
            end while (slot_ok == '0 && n < 40);
            found = 1'b0;
            got   = '0;
            for (int i = 0; i < NSLOTS; i++) begin
                if (slot_ok[i]) begin
                    found = 1'b1;
                    got   = slot_idx_t'(i);
                end
            end
            if (!found) begin
                report_failure("no slot_ok while all slots request");
            end else if (got !== slot_idx_t'(k % NSLOTS)) begin
                report_mismatch("granted slot", 32'(got), 32'(k % NSLOTS));
            end
            slots[got].cs <= 1'b0;
            // Request again one cycle later
            if (k < NSLOTS) begin
                @(posedge VB);
                slots[got].cs <= 1'b1;
            end
        end
        slots <= '0;
    endtask

    task automatic download_mapping();
        int          ok_start;
        ioctl_addr_t a;
        sdram_addr_t exp_addr;
        @(posedge VB);
        ok_start = ok_count;
        downloading <= 1'b1;
        slots[SLOT_SND] <= '{cs: 1'b1, wr: 1'b0, addr: 22'h00_0100, wrmask: 2'b11, din: '0};
        // Odd byte in the CPU region
        a        = 23'h01_2345;
        exp_addr = 22'h00_91A2;
        load_byte(a, 8'h5A, 1'b1);
        if (last_prog.bank !== 2'd1) report_mismatch("prog.bank", 32'(last_prog.bank), 32'h1);
        if (last_prog.addr !== exp_addr) begin
            report_mismatch("prog.addr", 32'(last_prog.addr), 32'(exp_addr));
        end
        if (last_prog.mask !== 2'b01) report_mismatch("prog.mask", 32'(last_prog.mask), 32'h1);
        if (last_prog.data !== 8'h5A) report_mismatch("prog.data", 32'(last_prog.data), 32'h5A);
        // Even byte in the graphics region
        a        = {GFX_OFFSET, 1'b0} + 23'h10;
        exp_addr = GFX_OFFSET + 22'h8;
        load_byte(a, 8'hC3, 1'b1);
        if (last_prog.bank !== 2'd0) report_mismatch("prog.bank", 32'(last_prog.bank), 32'h0);
        if (last_prog.addr !== exp_addr) begin
            report_mismatch("prog.addr", 32'(last_prog.addr), 32'(exp_addr));
        end
        if (last_prog.mask !== 2'b10) report_mismatch("prog.mask", 32'(last_prog.mask), 32'h2);
        if (ok_count != ok_start) report_failure("slot_ok pulsed during the download");
        @(posedge VB);
        slots[SLOT_SND].cs <= 1'b0;
        downloading        <= 1'b0;
    endtask

    task automatic config_region();
        int cfg_start;
        int wr_start;
        @(posedge VB);
        downloading <= 1'b1;
        cfg_start = cfg_pulses;
        wr_start  = prog_writes;
        load_byte({RAM_OFFSET, 1'b0} + 23'h3, 8'h81, 1'b0);
        repeat (4) @(posedge VB);
        if (cfg_pulses != cfg_start + 1) begin
            report_mismatch("cfg_we pulses", cfg_pulses - cfg_start, 1);
        end
        if (prog_writes != wr_start) report_failure("prog.we raised for a configuration byte");
        downloading <= 1'b0;
    endtask

    task automatic gfx_read();
        sdram_data_t dout;
        sdram_addr_t exp_addr;
        exp_addr = GFX_OFFSET + 22'h01_2345;
        slot_access(SLOT_GFX, 1'b0, 22'h01_2345, 2'b11, 16'h0000, dout);
        if (seen_cmd.addr !== exp_addr) begin
            report_mismatch("cmd.addr", 32'(seen_cmd.addr), 32'(exp_addr));
        end
        if (seen_cmd.bank !== 2'd0) report_mismatch("cmd.bank", 32'(seen_cmd.bank), 32'h0);
        if (seen_cmd.rnw !== 1'b1) report_mismatch("cmd.rnw", 32'(seen_cmd.rnw), 32'h1);
        if (dout !== model_word(exp_addr)) begin
            report_mismatch("slot_dout", dout, model_word(exp_addr));
        end
    endtask

    task automatic ram_write();
        sdram_data_t dout;
        sdram_addr_t exp_addr;
        exp_addr = RAM_OFFSET + 22'h00_0ABC;
        slot_access(SLOT_RAM, 1'b1, 22'h00_0ABC, 2'b10, 16'hBEEF, dout);
        if (seen_cmd.addr !== exp_addr) begin
            report_mismatch("cmd.addr", 32'(seen_cmd.addr), 32'(exp_addr));
        end
        if (seen_cmd.rnw !== 1'b0) report_mismatch("cmd.rnw", 32'(seen_cmd.rnw), 32'h0);
        if (seen_cmd.wrmask !== 2'b10) report_mismatch("cmd.wrmask", 32'(seen_cmd.wrmask), 32'h2);
        if (seen_cmd.data_write !== 16'hBEEF) begin
            report_mismatch("cmd.data_write", 32'(seen_cmd.data_write), 32'hBEEF);
        end
    endtask

    // Two windows of 240 cycles at random starting points
    task automatic cpu_enable_rate();
        int pulses;
        int r;
        int exp_pulses;
        exp_pulses = 240 * CEN_N / CEN_M;
        for (int w = 0; w < 2; w++) begin
            r = $random(seed);
            repeat (r & 15) @(posedge VB);
            pulses = 0;
            repeat (240) begin
                @(posedge VB);
                if (cpu_cen) pulses++;
            end
            if (pulses != exp_pulses) report_mismatch("cpu_cen pulses", pulses, exp_pulses);
        end
    endtask

    initial begin
        VB          = 1'b0;
        arst_n      = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        slots       = '0;
        seed        = 32'h527938c1;
        mismatches  = 0;
        failures    = 0;
        repeat (4) @(posedge VB);
        if ({sdram_req, prog.we, cfg_we, cpu_cen, slot_ok} !== '0) begin
            report_failure("strobes not low during reset");
        end
        if (refresh_en !== 1'b1) report_mismatch("refresh_en", 32'(refresh_en), 32'h1);
        arst_n <= 1'b1;
        repeat (2) @(posedge VB);
        round_robin();
        download_mapping();
        config_region();
        gfx_read();
        ram_write();
        cpu_enable_rate();
        repeat (4) @(posedge VB);
        $display("%0d value mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== compile.f ====
common/cps_pkg.sv
source/frac_cen.sv
loader/rom_loader.sv
sdram_mux/slot_arbiter.sv
sdram_mux/sdram_slot_mux.sv
source/game_mem_top.sv
dv/tb_game_mem_asserts.sv
dv/tb_game_mem.sv

// ==== Makefile ====
# Verilator simulation of the game memory block

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_game_mem -f compile.f -Mdir obj_dir
	./obj_dir/Vtb_game_mem | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "Test failed, see $(LOG)"; exit 1)
	@echo "Test passed"

clean:
	rm -rf obj_dir $(LOG)
